// ==== design/mega99_pkg.sv ====
`default_nettype none

package mega99_pkg;

   // TMS9918 colour index where 0 is transparent.
   typedef logic [3:0] color_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   // One pixel of the VDP video stream.
   typedef struct packed {
      logic   hsync;
      logic   cburst;
      color_t color;
   } vdp_pix_t;

   localparam int LINE_PIXELS   = 342;
   localparam int HSYNC_PIXELS  = 26;
   localparam int LINE_PTR_BITS = $clog2(LINE_PIXELS + 1);

   // System clocks per VDP pixel.
   localparam int CLK_DIV       = 10;
   localparam int CLK_CNT_BITS  = $clog2(CLK_DIV);

   localparam int AUDIO_BITS    = 16;

   // TMS9918 palette at 4 bits per channel.
   localparam rgb_t PALETTE [16] = '{
      '{4'h0, 4'h0, 4'h0},
      '{4'h0, 4'h0, 4'h0},
      '{4'h2, 4'hC, 4'h4},
      '{4'h5, 4'hD, 4'h7},
      '{4'h5, 4'h5, 4'hE},
      '{4'h7, 4'h7, 4'hF},
      '{4'hD, 4'h5, 4'h4},
      '{4'h4, 4'hE, 4'hF},
      '{4'hF, 4'h5, 4'h5},
      '{4'hF, 4'h7, 4'h7},
      '{4'hD, 4'hC, 4'h5},
      '{4'hE, 4'hC, 4'h8},
      '{4'h2, 4'hB, 4'h3},
      '{4'hC, 4'h5, 4'hB},
      '{4'hC, 4'hC, 4'hC},
      '{4'hF, 4'hF, 4'hF}
   };

endpackage

`default_nettype wire

// ==== design/video_clk_gen.sv ====
`default_nettype none

module video_clk_gen
   import mega99_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   output logic vdp_clk_en_o,
   output logic vga_clk_en_o
);

   localparam logic [CLK_CNT_BITS-1:0] CNT_LAST = CLK_CNT_BITS'(CLK_DIV - 1);
   localparam logic [CLK_CNT_BITS-1:0] CNT_HALF = CLK_CNT_BITS'(CLK_DIV / 2);

   logic [CLK_CNT_BITS-1:0] cnt_q;

   // Starts at the last count so the first strobe follows reset release.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= CNT_LAST;
      end else if (cnt_q == CNT_LAST) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign vdp_clk_en_o = (cnt_q == '0);

   // VGA runs at twice the pixel rate, in step with the VDP strobe.
   assign vga_clk_en_o = (cnt_q == '0) || (cnt_q == CNT_HALF);

endmodule

`default_nettype wire

// ==== design/tms9918_scandoubler.sv ====
`default_nettype none

module tms9918_scandoubler
   import mega99_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     vdp_clk_en_i,
   input  logic     vga_clk_en_i,
   input  vdp_pix_t pix_i,
   output vdp_pix_t pix_o
);

   localparam logic [LINE_PTR_BITS-1:0] PTR_LAST  = LINE_PTR_BITS'(LINE_PIXELS - 1);
   localparam logic [LINE_PTR_BITS-1:0] PTR_END   = LINE_PTR_BITS'(LINE_PIXELS);
   localparam logic [LINE_PTR_BITS-1:0] PTR_HSYNC = LINE_PTR_BITS'(HSYNC_PIXELS);

   // One line bank is written while the other is replayed.
   color_t col_mem   [2][LINE_PIXELS];
   logic   burst_mem [2][LINE_PIXELS];

   logic                     hsync_in_q;
   logic                     wr_bank_q;
   logic [LINE_PTR_BITS-1:0] wr_ptr_q;
   logic                     line_start;
   logic                     wr_bank;
   logic [LINE_PTR_BITS-1:0] wr_addr;
   logic                     wr_en;

   logic [LINE_PTR_BITS-1:0] rd_ptr_q;
   logic                     copy_q;
   logic                     rd_stb_q;
   logic                     seen_line_q;
   logic                     rd_valid_q;
   logic                     rd_bank;

   // Rising edge of the input sync opens a new line at pixel 0.
   assign line_start = vdp_clk_en_i && pix_i.hsync && !hsync_in_q;
   assign wr_bank    = line_start ? !wr_bank_q : wr_bank_q;
   assign wr_addr    = line_start ? '0 : wr_ptr_q;
   assign wr_en      = vdp_clk_en_i && (wr_addr < PTR_END);
   assign rd_bank    = !wr_bank_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hsync_in_q <= 1'b0;
         wr_bank_q  <= 1'b0;
         wr_ptr_q   <= PTR_END;
      end else if (vdp_clk_en_i) begin
         hsync_in_q <= pix_i.hsync;
         wr_bank_q  <= wr_bank;
         if (wr_en) begin
            wr_ptr_q <= wr_addr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         col_mem[wr_bank][wr_addr]   <= pix_i.color;
         burst_mem[wr_bank][wr_addr] <= pix_i.cburst;
      end
   end

   // Replay the finished bank twice, then wait for the next line.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ptr_q    <= '0;
         copy_q      <= 1'b0;
         rd_stb_q    <= 1'b0;
         seen_line_q <= 1'b0;
         rd_valid_q  <= 1'b0;
      end else begin
         rd_stb_q <= vga_clk_en_i;
         if (line_start) begin
            rd_ptr_q    <= '0;
            copy_q      <= 1'b0;
            seen_line_q <= 1'b1;
            // The bank replayed after the first line was never written.
            rd_valid_q  <= seen_line_q;
         end else if (vga_clk_en_i) begin
            if (rd_ptr_q != PTR_LAST) begin
               rd_ptr_q <= rd_ptr_q + 1'b1;
            end else if (!copy_q) begin
               rd_ptr_q <= '0;
               copy_q   <= 1'b1;
            end
         end
      end
   end

   // The output stage runs one cycle behind the pointer update.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pix_o <= '0;
      end else if (rd_stb_q) begin
         pix_o.hsync  <= seen_line_q && (rd_ptr_q < PTR_HSYNC);
         pix_o.cburst <= rd_valid_q && burst_mem[rd_bank][rd_ptr_q];
         pix_o.color  <= rd_valid_q ? col_mem[rd_bank][rd_ptr_q] : '0;
      end
   end

endmodule

`default_nettype wire

// ==== design/tms9918_color_to_rgb.sv ====
`default_nettype none

module tms9918_color_to_rgb
   import mega99_pkg::*;
(
   input  logic   clk_i,
   input  logic   arst_n_i,
   input  color_t color_i,
   input  color_t overlay_i,
   input  logic   hsync_i,
   output rgb_t   rgb_o,
   output logic   hsync_o
);

   color_t sel_color;

   // Any non-transparent overlay pixel wins.
   assign sel_color = (overlay_i != '0) ? overlay_i : color_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rgb_o   <= '0;
         hsync_o <= 1'b0;
      end else begin
         rgb_o   <= PALETTE[sel_color];
         // Sync takes the same register stage as the colour.
         hsync_o <= hsync_i;
      end
   end

endmodule

`default_nettype wire

// ==== design/sigmadelta.sv ====
`default_nettype none

module sigmadelta
   import mega99_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic [AUDIO_BITS-1:0] sample_i,
   output logic                  q_o
);

   logic [AUDIO_BITS-1:0] acc_q;
   logic [AUDIO_BITS:0]   sum;

   // Carry out of the accumulator is the one-bit output.
   assign sum = {1'b0, acc_q} + {1'b0, sample_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acc_q <= '0;
         q_o   <= 1'b0;
      end else begin
         acc_q <= sum[AUDIO_BITS-1:0];
         q_o   <= sum[AUDIO_BITS];
      end
   end

endmodule

`default_nettype wire

// ==== design/mega99_av_top.sv ====
`default_nettype none

module mega99_av_top
   import mega99_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  vdp_pix_t              vdp_pix_i,
   input  color_t                overlay_i,
   input  logic [AUDIO_BITS-1:0] audio_i,
   output logic                  vdp_clk_en_o,
   output logic                  vga_hsync_o,
   output logic                  aud_pwm_o,
   output rgb_t                  vga_rgb_o
);

   logic     vga_clk_en;
   vdp_pix_t vga_pix;

   video_clk_gen clkgen (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .vdp_clk_en_o (vdp_clk_en_o),
      .vga_clk_en_o (vga_clk_en)
   );

   tms9918_scandoubler scandoubler (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .vdp_clk_en_i (vdp_clk_en_o),
      .vga_clk_en_i (vga_clk_en),
      .pix_i        (vdp_pix_i),
      .pix_o        (vga_pix)
   );

   // Overlay sits on top of the doubled picture.
   tms9918_color_to_rgb vga_color_to_rgb (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .color_i   (vga_pix.color),
      .overlay_i (overlay_i),
      .hsync_i   (vga_pix.hsync),
      .rgb_o     (vga_rgb_o),
      .hsync_o   (vga_hsync_o)
   );

   sigmadelta sd_dac (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .sample_i (audio_i),
      .q_o      (aud_pwm_o)
   );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   // Period of 10 time units.
   always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tests/av_props.sv ====
`default_nettype none

module av_props
   import mega99_pkg::*;
(
   input logic                     clk_i,
   input logic                     arst_n_i,
   input logic                     vdp_clk_en_i,
   input logic                     vga_clk_en_i,
   input logic                     rd_stb_i,
   input logic [LINE_PTR_BITS-1:0] rd_ptr_i,
   input vdp_pix_t                 pix_i
);

   int hsync_run;

   // Strobes seen while the output sync is high.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hsync_run <= 0;
      end else if (!pix_i.hsync) begin
         hsync_run <= 0;
      end else if (rd_stb_i) begin
         hsync_run <= hsync_run + 1;
      end
   end

   strobe_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      vdp_clk_en_i |-> vga_clk_en_i)
      else $error("VGA strobe missing on a VDP strobe");

   ptr_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_ptr_i <= LINE_PTR_BITS'(LINE_PIXELS - 1))
      else $error("Read pointer past the end of the line");

   hsync_width: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hsync_run <= HSYNC_PIXELS)
      else $error("Output hsync held for too many strobes");

endmodule

`default_nettype wire

// ==== tests/av_checker.sv ====
`default_nettype none

module av_checker
   import mega99_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  vdp_clk_en_i,
   input  vdp_pix_t              vdp_pix_i,
   input  color_t                overlay_i,
   input  logic                  vga_hsync_i,
   input  rgb_t                  vga_rgb_i,
   input  logic                  aud_pwm_i,
   input  logic [AUDIO_BITS-1:0] audio_i,
   input  logic                  aud_measure_i,
   output int                    pix_errs_o,
   output int                    line_errs_o,
   output int                    aud_errs_o,
   output int                    rst_errs_o
);

   color_t cur_line  [LINE_PIXELS];
   color_t prev_line [LINE_PIXELS];

   int   in_lines = 0;
   int   in_idx = 0;
   logic in_hsync_q = 1'b0;
   int   strobe_gap = 0;
   logic strobe_seen = 1'b0;
   int   out_lines = 0;
   int   out_pix = 0;
   int   out_phase = 0;
   logic out_active = 1'b0;
   logic out_hsync_q = 1'b0;
   int   aud_ones = 0;
   int   aud_cycles = 0;
   logic meas_q = 1'b0;
   logic meas_seen = 1'b0;

   initial begin
      pix_errs_o  = 0;
      line_errs_o = 0;
      aud_errs_o  = 0;
      rst_errs_o  = 0;
   end

   task automatic record_input();
      strobe_gap++;
      if (vdp_clk_en_i) begin
         // The VDP strobe repeats every CLK_DIV cycles.
         if (strobe_seen && strobe_gap != CLK_DIV) begin
            $display("CHECK FAILED vdp_clk_en_o period: got %h, expected %h",
                     strobe_gap, CLK_DIV);
            line_errs_o++;
         end
         strobe_gap  = 0;
         strobe_seen = 1'b1;
         if (vdp_pix_i.hsync && !in_hsync_q) begin
            // Two VGA lines belong to each full input line.
            if (in_lines >= 3 && out_lines != 2) begin
               $display("CHECK FAILED vga_hsync_o lines per input line: got %h, expected %h",
                        out_lines, 2);
               line_errs_o++;
            end
            prev_line = cur_line;
            in_lines++;
            in_idx = 0;
            out_lines = 0;
         end
         if (in_idx < LINE_PIXELS) begin
            cur_line[in_idx] = vdp_pix_i.color;
         end
         in_idx++;
         in_hsync_q = vdp_pix_i.hsync;
      end
   endtask

   task automatic compare_video();
      rgb_t exp_rgb;
      logic exp_hs;
      if (vga_hsync_i && !out_hsync_q) begin
         if (out_active && out_pix != LINE_PIXELS) begin
            $display("CHECK FAILED vga_rgb_o pixels per line: got %h, expected %h",
                     out_pix, LINE_PIXELS);
            line_errs_o++;
         end
         out_active = (in_lines >= 3);
         out_pix = 0;
         out_phase = 0;
         out_lines++;
      end
      out_hsync_q = vga_hsync_i;
      if (out_phase == 0) begin
         if (out_active && out_pix < LINE_PIXELS) begin
            exp_hs  = (out_pix < HSYNC_PIXELS);
            exp_rgb = (overlay_i != '0) ? PALETTE[overlay_i] : PALETTE[prev_line[out_pix]];
            if (vga_hsync_i !== exp_hs) begin
               $display("CHECK FAILED vga_hsync_o pixel %0d: got %h, expected %h",
                        out_pix, vga_hsync_i, exp_hs);
               pix_errs_o++;
            end
            if (vga_rgb_i !== exp_rgb) begin
               $display("CHECK FAILED vga_rgb_o pixel %0d: got %h, expected %h",
                        out_pix, vga_rgb_i, exp_rgb);
               pix_errs_o++;
            end
         end
         out_pix++;
      end
      out_phase = (out_phase == CLK_DIV / 2 - 1) ? 0 : out_phase + 1;
   endtask

   task automatic count_audio_ones();
      if (meas_q) begin
         aud_cycles++;
         if (aud_pwm_i) begin
            aud_ones++;
         end
         meas_seen = 1'b1;
      end else if (meas_seen) begin
         // A full accumulator period gives exactly as many ones as the sample.
         if (aud_cycles != (1 << AUDIO_BITS)) begin
            $display("Audio window had %0d cycles instead of a full period", aud_cycles);
            aud_errs_o++;
         end
         if (aud_ones != int'(audio_i)) begin
            $display("CHECK FAILED aud_pwm_o ones: got %h, expected %h", aud_ones, audio_i);
            aud_errs_o++;
         end
         aud_ones = 0;
         aud_cycles = 0;
         meas_seen = 1'b0;
      end
   endtask

   // The measurement window lags the flag by one rising edge.
   always @(posedge clk_i) begin
      meas_q <= aud_measure_i;
   end

   always @(negedge clk_i) begin
      if (!arst_n_i) begin
         if (vga_hsync_i !== 1'b0 || vga_rgb_i !== '0 || aud_pwm_i !== 1'b0) begin
            $display("Outputs are not all zero while reset is held");
            rst_errs_o++;
         end
      end else begin
         record_input();
         compare_video();
         count_audio_ones();
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_mega99_av.sv ====
`default_nettype none

module tb_mega99_av
   import mega99_pkg::*;
;

   localparam int MAX_RECORDS    = 64;
   localparam int STROBE_TIMEOUT = 4 * CLK_DIV;

   logic                  clk;
   logic                  arst_n;
   vdp_pix_t              vdp_pix;
   color_t                overlay;
   logic [AUDIO_BITS-1:0] audio;
   logic                  aud_measure;
   logic                  vdp_clk_en;
   logic                  vga_hsync;
   logic                  aud_pwm;
   rgb_t                  vga_rgb;

   logic [31:0] records [MAX_RECORDS];
   logic [31:0] lfsr;
   int          timeouts;
   int          bad_records;
   int          pix_errs;
   int          line_errs;
   int          aud_errs;
   int          rst_errs;

   tb_clock clock_gen (
      .clk_o (clk)
   );

   mega99_av_top UUT (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .vdp_pix_i    (vdp_pix),
      .overlay_i    (overlay),
      .audio_i      (audio),
      .vdp_clk_en_o (vdp_clk_en),
      .vga_hsync_o  (vga_hsync),
      .aud_pwm_o    (aud_pwm),
      .vga_rgb_o    (vga_rgb)
   );

   av_checker monitor (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .vdp_clk_en_i  (vdp_clk_en),
      .vdp_pix_i     (vdp_pix),
      .overlay_i     (overlay),
      .vga_hsync_i   (vga_hsync),
      .vga_rgb_i     (vga_rgb),
      .aud_pwm_i     (aud_pwm),
      .audio_i       (audio),
      .aud_measure_i (aud_measure),
      .pix_errs_o    (pix_errs),
      .line_errs_o   (line_errs),
      .aud_errs_o    (aud_errs),
      .rst_errs_o    (rst_errs)
   );

   bind tms9918_scandoubler av_props props (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .vdp_clk_en_i (vdp_clk_en_i),
      .vga_clk_en_i (vga_clk_en_i),
      .rd_stb_i     (rd_stb_q),
      .rd_ptr_i     (rd_ptr_q),
      .pix_i        (pix_o)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per colour bit.
   task automatic draw_color(output color_t c);
      int i;
      for (i = 0; i < 4; i++) begin
         lfsr = lfsr_next(lfsr);
         c[i] = lfsr[0];
      end
   endtask

   task automatic wait_vdp_strobe();
      int n;
      n = 0;
      while (vdp_clk_en !== 1'b1 && n < STROBE_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (vdp_clk_en !== 1'b1) begin
         $display("Timed out waiting for the VDP pixel strobe");
         timeouts++;
      end
   endtask

   task automatic drive_line(input color_t seed, input color_t ovl);
      int     k;
      color_t c;
      for (k = 0; k < LINE_PIXELS && timeouts == 0; k++) begin
         draw_color(c);
         vdp_pix.hsync  = (k < HSYNC_PIXELS);
         vdp_pix.cburst = (k >= 30 && k < 44);
         vdp_pix.color  = c ^ seed;
         wait_vdp_strobe();
         @(negedge clk);
         // Overlay switches after the strobe that opens the line.
         if (k == 0) begin
            overlay = ovl;
         end
      end
   endtask

   task automatic measure_audio(input logic [AUDIO_BITS-1:0] d);
      int n;
      audio = d;
      @(negedge clk);
      aud_measure = 1'b1;
      for (n = 0; n < 2 ** AUDIO_BITS; n++) begin
         @(negedge clk);
      end
      aud_measure = 1'b0;
      @(negedge clk);
      @(negedge clk);
   endtask

   initial begin
      int          r;
      int          total;
      logic [31:0] rec;
      vdp_pix     = '0;
      overlay     = '0;
      audio       = '0;
      aud_measure = 1'b0;
      arst_n      = 1'b0;
      lfsr        = 32'ha3fe1b4b;
      timeouts    = 0;
      bad_records = 0;
      for (r = 0; r < MAX_RECORDS; r++) begin
         records[r] = 32'hF000_0000;
      end
      $readmemh("tests/av_input.hex", records);
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
      wait_vdp_strobe();
      @(negedge clk);
      r = 0;
      while (r < MAX_RECORDS && records[r][31:28] != 4'hF && timeouts == 0) begin
         rec = records[r];
         case (rec[31:28])
            4'h1: drive_line(rec[23:20], rec[27:24]);
            4'h2: measure_audio(rec[15:0]);
            default: begin
               $display("Unknown record kind in entry %0d of the input file", r);
               bad_records++;
            end
         endcase
         r++;
      end
      repeat (4) @(negedge clk);
      total = pix_errs + line_errs + aud_errs + rst_errs + timeouts + bad_records;
      $display("Errors: pixel %0d, line %0d, audio %0d, reset %0d, timeout %0d, record %0d",
               pix_errs, line_errs, aud_errs, rst_errs, timeouts, bad_records);
      if (total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== mega99_av_top.f ====
design/mega99_pkg.sv
design/video_clk_gen.sv
design/tms9918_scandoubler.sv
design/tms9918_color_to_rgb.sv
design/sigmadelta.sv
design/mega99_av_top.sv
tests/tb_clock.sv
tests/av_props.sv
tests/av_checker.sv
tests/tb_mega99_av.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   -f mega99_av_top.f \
   --top-module tb_mega99_av \
   -o tb_mega99_av
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_mega99_av > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
exit 0

// ==== tests/av_input.hex ====
// Kind in [31:28]: 1 video line, 2 audio sample, F end of records.
// Line: overlay in [27:24], colour seed xored into LFSR pixels in [23:20].
// Audio: sample in [15:0], held for one full accumulator period.
10000000
10000000
10300000
10000000
10A00000
10500000
10000000
10F00000
10100000
10000000
10700000
10000000
12000000
1F400000
17900000
10900000
10000000
10C00000
10200000
10000000
10600000
10000000
10B00000
10000000
13000000
13800000
10800000
10000000
10D00000
10000000
10E00000
10000000
10400000
10000000
10000000
10000000
20000000
20008000
20001234
2000FFFF
F0000000
